// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction field positions
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int RD_MSB  = 4;
    localparam int RD_LSB  = 0;
    localparam int RJ_MSB  = 9;
    localparam int RJ_LSB  = 5;
    localparam int RK_MSB  = 14;
    localparam int RK_LSB  = 10;
    localparam int IMM_MSB = 21;
    localparam int IMM_LSB = 10;
    localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

    // codes outside this list decode as nop
    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SLT  = 6'd6,
        OP_ADDI = 6'd7,
        OP_MUL  = 6'd8
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // result select at writeback
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

endpackage

`default_nettype wire

// ==== source/inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_mem import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                          clk,
    input  logic                         load_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
    input  word_t                        load_data,
    input  logic                         fetch_req,
    input  logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr,
    output word_t                        inst_lo,
    output word_t                        inst_hi
);

    word_t mem [IMEM_DEPTH];

    // program load, one word per cycle
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    // aligned pair, ready the cycle after the request
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            inst_lo <= mem[fetch_addr];
            inst_hi <= mem[fetch_addr | 1'b1];
        end
    end

    a_pair_aligned: assert property (@(posedge clk) fetch_req |-> fetch_addr[0] == 1'b0);

endmodule

`default_nettype wire

// ==== source/fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int FB_DEPTH   = 4
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  logic                          issue0,
    input  logic                          issue1,
    input  word_t                         inst_lo,
    input  word_t                         inst_hi,
    output logic                          fetch_req,
    output logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr,
    output word_t                         head0,
    output word_t                         head1,
    output logic                          head0_valid,
    output logic                          head1_valid,
    output logic                          fetch_done,
    output logic                          empty
);

    localparam int AW  = $clog2(IMEM_DEPTH);
    localparam int PCW = AW + 1;
    localparam int PW  = $clog2(FB_DEPTH);
    localparam int CW  = $clog2(FB_DEPTH + 1);

    word_t             queue [FB_DEPTH];
    logic [PW-1:0]     rd_ptr;
    logic [PW-1:0]     wr_ptr;
    logic [CW-1:0]     count;
    logic [CW:0]       reserved;
    logic [CW:0]       count_sum;
    logic [1:0]        pop_cnt;
    logic [PCW-1:0]    pc;
    logic              in_flight;
    logic              started;

    function automatic logic [PW-1:0] wrap_inc(input logic [PW-1:0] p);
        return (p == PW'(FB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // entries held plus the pair already on its way
    assign reserved  = {1'b0, count} + (in_flight ? (CW+1)'(2) : '0);
    assign fetch_req = started && (reserved + (CW+1)'(2) <= (CW+1)'(FB_DEPTH))
                       && (pc < PCW'(IMEM_DEPTH));
    assign fetch_addr = pc[AW-1:0];

    assign pop_cnt   = issue1 ? 2'd2 : (issue0 ? 2'd1 : 2'd0);
    assign count_sum = reserved - (CW+1)'(pop_cnt);

    assign head0       = queue[rd_ptr];
    assign head1       = queue[wrap_inc(rd_ptr)];
    assign head0_valid = (count >= CW'(1));
    assign head1_valid = (count >= CW'(2));
    assign empty       = (count == '0);
    assign fetch_done  = (pc == PCW'(IMEM_DEPTH)) && !in_flight;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            started   <= 1'b0;
            pc        <= '0;
            in_flight <= 1'b0;
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
        end else begin
            started   <= 1'b1;
            in_flight <= fetch_req;
            count     <= count_sum[CW-1:0];
            if (fetch_req) begin
                pc <= pc + PCW'(2);
            end
            if (in_flight) begin
                wr_ptr <= wrap_inc(wrap_inc(wr_ptr));
            end
            if (issue1) begin
                rd_ptr <= wrap_inc(wrap_inc(rd_ptr));
            end else if (issue0) begin
                rd_ptr <= wrap_inc(rd_ptr);
            end
        end
    end

    // returned pair lands in two consecutive entries
    always_ff @(posedge clk) begin
        if (in_flight) begin
            queue[wr_ptr]           <= inst_lo;
            queue[wrap_inc(wr_ptr)] <= inst_hi;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        count_sum <= (CW+1)'(FB_DEPTH));
    a_issue_order: assert property (@(posedge clk) disable iff (!rstn)
        issue1 |-> issue0);

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
    input  word_t     inst,
    output reg_addr_t rd,
    output reg_addr_t rj,
    output reg_addr_t rk,
    output word_t     imm,
    output alu_op_e   alu_op,
    output logic      use_imm,
    output unit_e     unit,
    output logic      wen,
    output logic      reads_rk
);

    opcode_e opcode;
    logic    writes;

    assign opcode = opcode_e'(inst[OPC_MSB:OPC_LSB]);
    assign rd     = inst[RD_MSB:RD_LSB];
    assign rj     = inst[RJ_MSB:RJ_LSB];
    assign rk     = inst[RK_MSB:RK_LSB];
    assign imm    = {{(XLEN-IMM_W){inst[IMM_MSB]}}, inst[IMM_MSB:IMM_LSB]};

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b0;
        unit     = UNIT_ALU;
        writes   = 1'b1;
        reads_rk = 1'b1;
        case (opcode)
            OP_ADD: alu_op = ALU_ADD;
            OP_SUB: alu_op = ALU_SUB;
            OP_AND: alu_op = ALU_AND;
            OP_OR:  alu_op = ALU_OR;
            OP_XOR: alu_op = ALU_XOR;
            OP_SLT: alu_op = ALU_SLT;
            OP_ADDI: begin
                use_imm  = 1'b1;
                reads_rk = 1'b0;
            end
            OP_MUL: unit = UNIT_MUL;
            // nop and undefined codes
            default: begin
                writes   = 1'b0;
                reads_rk = 1'b0;
            end
        endcase
    end

    // r0 is never a real destination
    assign wen = writes && (rd != '0);

endmodule

`default_nettype wire

// ==== source/dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatcher import cpu_pkg::*; (
    input  logic      head0_valid,
    input  logic      head1_valid,
    input  reg_addr_t rd0,
    input  logic      wen0,
    input  reg_addr_t rj1,
    input  reg_addr_t rk1,
    input  logic      reads_rk1,
    input  reg_addr_t rd1,
    input  logic      wen1,
    input  unit_e     unit1,
    output logic      issue0,
    output logic      issue1
);

    logic raw;
    logic waw;
    logic pair_ok;

    // slot 1 depends on slot 0 result
    assign raw = wen0 && ((rj1 == rd0) || (reads_rk1 && (rk1 == rd0)));

    // both write the same register
    assign waw = wen0 && wen1 && (rd1 == rd0);

    // only lane 0 multiplies
    assign pair_ok = head1_valid && (unit1 != UNIT_MUL) && !raw && !waw;

    // head always goes, no stall sources
    assign issue0 = head0_valid;
    assign issue1 = head0_valid && pair_ok;

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire       clk,
    input  wire       rstn,
    input  logic      we0,
    input  logic      we1,
    input  reg_addr_t waddr0,
    input  reg_addr_t waddr1,
    input  word_t     wdata0,
    input  word_t     wdata1,
    input  reg_addr_t raddr_j0,
    input  reg_addr_t raddr_k0,
    input  reg_addr_t raddr_j1,
    input  reg_addr_t raddr_k1,
    output word_t     rdata_j0,
    output word_t     rdata_k0,
    output word_t     rdata_j1,
    output word_t     rdata_k1
);

    word_t regs [NUM_REGS];

    // write-through, lane 1 is the younger write
    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (we1 && (waddr1 == addr)) begin
            val = wdata1;
        end else if (we0 && (waddr0 == addr)) begin
            val = wdata0;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rdata_j0 = read_port(raddr_j0);
    assign rdata_k0 = read_port(raddr_k0);
    assign rdata_j1 = read_port(raddr_j1);
    assign rdata_k1 = read_port(raddr_k1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && (waddr0 != '0)) begin
                regs[waddr0] <= wdata0;
            end
            if (we1 && (waddr1 != '0)) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // dispatcher keeps same-destination pairs apart
    a_no_dual_write: assert property (@(posedge clk) disable iff (!rstn)
        (we0 && we1) |-> (waddr0 != waddr1));

endmodule

`default_nettype wire

// ==== source/exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_lane import cpu_pkg::*; #(
    parameter bit HAS_MUL = 1'b1
) (
    input  wire       clk,
    input  wire       rstn,
    input  logic      issue,
    input  reg_addr_t rd,
    input  reg_addr_t rj,
    input  reg_addr_t rk,
    input  word_t     imm,
    input  alu_op_e   alu_op,
    input  logic      use_imm,
    input  unit_e     unit,
    input  logic      wen,
    output reg_addr_t raddr_j,
    output reg_addr_t raddr_k,
    input  word_t     rdata_j,
    input  word_t     rdata_k,
    output logic      busy,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    // decode stage
    logic      d_valid;
    logic      d_wen;
    reg_addr_t d_rd;
    reg_addr_t d_rj;
    reg_addr_t d_rk;
    word_t     d_imm;
    alu_op_e   d_alu_op;
    logic      d_use_imm;
    unit_e     d_unit;

    // execute stage
    logic      x_valid;
    logic      x_wen;
    reg_addr_t x_rd;
    word_t     x_alu;
    word_t     x_mul;
    unit_e     x_unit;

    // writeback stage
    logic      w_valid;
    logic      w_wen;

    word_t     op_b;
    word_t     alu_res;
    word_t     mul_res;

    assign raddr_j = d_rj;
    assign raddr_k = d_rk;
    assign op_b    = d_use_imm ? d_imm : rdata_k;

    always_comb begin
        case (d_alu_op)
            ALU_SUB: alu_res = rdata_j - op_b;
            ALU_AND: alu_res = rdata_j & op_b;
            ALU_OR:  alu_res = rdata_j | op_b;
            ALU_XOR: alu_res = rdata_j ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(rdata_j) < $signed(op_b)};
            default: alu_res = rdata_j + op_b;
        endcase
    end

    // low word of the product only
    if (HAS_MUL) begin : g_mul
        assign mul_res = rdata_j * rdata_k;
    end else begin : g_no_mul
        assign mul_res = '0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            d_valid <= 1'b0;
            x_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            d_valid <= issue;
            x_valid <= d_valid;
            w_valid <= x_valid;
        end
    end

    always_ff @(posedge clk) begin
        d_wen     <= wen;
        d_rd      <= rd;
        d_rj      <= rj;
        d_rk      <= rk;
        d_imm     <= imm;
        d_alu_op  <= alu_op;
        d_use_imm <= use_imm;
        d_unit    <= unit;
        x_wen     <= d_wen;
        x_rd      <= d_rd;
        x_alu     <= alu_res;
        x_mul     <= mul_res;
        x_unit    <= d_unit;
        w_wen     <= x_wen;
        wb_addr   <= x_rd;
        wb_data   <= (x_unit == UNIT_MUL) ? x_mul : x_alu;
    end

    assign wb_valid = w_valid && w_wen;
    assign busy     = d_valid || x_valid || w_valid;

    a_mul_lane_only: assert property (@(posedge clk) disable iff (!rstn)
        (!HAS_MUL && issue) |-> (unit != UNIT_MUL));

endmodule

`default_nettype wire

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int FB_DEPTH   = 4
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  logic                          load_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
    input  word_t                         load_data,
    output logic                          wb_valid0,
    output reg_addr_t                     wb_addr0,
    output word_t                         wb_data0,
    output logic                          wb_valid1,
    output reg_addr_t                     wb_addr1,
    output word_t                         wb_data1,
    output logic                          idle
);

    localparam int AW = $clog2(IMEM_DEPTH);

    logic          fetch_req;
    logic [AW-1:0] fetch_addr;
    word_t         inst_lo;
    word_t         inst_hi;
    word_t         head0;
    word_t         head1;
    logic          head0_valid;
    logic          head1_valid;
    logic          fetch_done;
    logic          empty;
    logic          issue0;
    logic          issue1;
    logic          busy0;
    logic          busy1;

    // decoded slot fields
    reg_addr_t     rd0, rj0, rk0;
    reg_addr_t     rd1, rj1, rk1;
    word_t         imm0, imm1;
    alu_op_e       alu_op0, alu_op1;
    logic          use_imm0, use_imm1;
    unit_e         unit0, unit1;
    logic          wen0, wen1;
    logic          reads_rk0, reads_rk1;

    // register file read side
    reg_addr_t     raddr_j0, raddr_k0, raddr_j1, raddr_k1;
    word_t         rdata_j0, rdata_k0, rdata_j1, rdata_k1;

    inst_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_inst_mem (
        .clk(clk), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .inst_lo(inst_lo), .inst_hi(inst_hi)
    );

    fetch_buffer #(.IMEM_DEPTH(IMEM_DEPTH), .FB_DEPTH(FB_DEPTH)) u_fetch_buffer (
        .clk(clk), .rstn(rstn), .issue0(issue0), .issue1(issue1),
        .inst_lo(inst_lo), .inst_hi(inst_hi),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .head0(head0), .head1(head1), .head0_valid(head0_valid), .head1_valid(head1_valid),
        .fetch_done(fetch_done), .empty(empty)
    );

    decoder u_decoder0 (
        .inst(head0), .rd(rd0), .rj(rj0), .rk(rk0), .imm(imm0), .alu_op(alu_op0),
        .use_imm(use_imm0), .unit(unit0), .wen(wen0), .reads_rk(reads_rk0)
    );

    decoder u_decoder1 (
        .inst(head1), .rd(rd1), .rj(rj1), .rk(rk1), .imm(imm1), .alu_op(alu_op1),
        .use_imm(use_imm1), .unit(unit1), .wen(wen1), .reads_rk(reads_rk1)
    );

    // slot 0 rk usage never blocks pairing
    dispatcher u_dispatcher (
        .head0_valid(head0_valid), .head1_valid(head1_valid), .rd0(rd0), .wen0(wen0),
        .rj1(rj1), .rk1(rk1), .reads_rk1(reads_rk1), .rd1(rd1), .wen1(wen1),
        .unit1(unit1), .issue0(issue0), .issue1(issue1)
    );

    register_file u_register_file (
        .clk(clk), .rstn(rstn),
        .we0(wb_valid0), .we1(wb_valid1), .waddr0(wb_addr0), .waddr1(wb_addr1),
        .wdata0(wb_data0), .wdata1(wb_data1),
        .raddr_j0(raddr_j0), .raddr_k0(raddr_k0), .raddr_j1(raddr_j1), .raddr_k1(raddr_k1),
        .rdata_j0(rdata_j0), .rdata_k0(rdata_k0), .rdata_j1(rdata_j1), .rdata_k1(rdata_k1)
    );

    // lane 0 always carries the older instruction
    exec_lane #(.HAS_MUL(1'b1)) u_lane0 (
        .clk(clk), .rstn(rstn), .issue(issue0),
        .rd(rd0), .rj(rj0), .rk(reads_rk0 ? rk0 : '0), .imm(imm0), .alu_op(alu_op0),
        .use_imm(use_imm0), .unit(unit0), .wen(wen0),
        .raddr_j(raddr_j0), .raddr_k(raddr_k0), .rdata_j(rdata_j0), .rdata_k(rdata_k0),
        .busy(busy0), .wb_valid(wb_valid0), .wb_addr(wb_addr0), .wb_data(wb_data0)
    );

    exec_lane #(.HAS_MUL(1'b0)) u_lane1 (
        .clk(clk), .rstn(rstn), .issue(issue1),
        .rd(rd1), .rj(rj1), .rk(rk1), .imm(imm1), .alu_op(alu_op1),
        .use_imm(use_imm1), .unit(unit1), .wen(wen1),
        .raddr_j(raddr_j1), .raddr_k(raddr_k1), .rdata_j(rdata_j1), .rdata_k(rdata_k1),
        .busy(busy1), .wb_valid(wb_valid1), .wb_addr(wb_addr1), .wb_data(wb_data1)
    );

    // program fully fetched and drained
    assign idle = fetch_done && empty && !busy0 && !busy1;

endmodule

`default_nettype wire

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// register format, bits 25 to 15 unused
function automatic word_t enc_r(opcode_e op, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
    return {op, 11'b0, rk, rj, rd};
endfunction

// immediate format, low 12 bits of imm kept
function automatic word_t enc_i(opcode_e op, reg_addr_t rd, reg_addr_t rj, int imm);
    logic [11:0] imm12;
    imm12 = imm[11:0];
    return {op, 4'b0, imm12, rj, rd};
endfunction

// in-order execution of prog, expected writeback stream
task automatic predict_writebacks();
    word_t     regs [32];
    word_t     inst;
    word_t     a;
    word_t     b;
    word_t     imm;
    word_t     res;
    reg_addr_t rd;
    logic      writes;
    foreach (regs[r]) begin
        regs[r] = '0;
    end
    exp_addr.delete();
    exp_data.delete();
    exp_rj.delete();
    exp_rk.delete();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
        inst   = prog[i];
        rd     = inst[4:0];
        a      = regs[inst[9:5]];
        b      = regs[inst[14:10]];
        imm    = {{20{inst[21]}}, inst[21:10]};
        writes = 1'b1;
        res    = '0;
        case (inst[31:26])
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = a + imm;
            OP_MUL:  res = a * b;
            default: writes = 1'b0;
        endcase
        if (writes && (rd != 0)) begin
            regs[rd] = res;
            exp_addr.push_back(rd);
            exp_data.push_back(res);
            exp_rj.push_back(inst[9:5]);
            // addi has no second register source
            exp_rk.push_back((inst[31:26] == OP_ADDI) ? inst[9:5] : inst[14:10]);
        end
    end
endtask

task automatic check_wb(int idx, reg_addr_t exp_a, word_t exp_d, reg_addr_t act_a,
                        word_t act_d);
    if ((exp_a !== act_a) || (exp_d !== act_d)) begin
        stop_on_failure($sformatf("ERR %s: writeback %0d expected r%0d=%h, actual r%0d=%h",
                                  test_name, idx, exp_a, exp_d, act_a, act_d));
    end
endtask

task automatic check_count(int exp_n, int act_n);
    if (exp_n != act_n) begin
        stop_on_failure($sformatf("ERR %s: writeback count expected %0d, actual %0d",
                                  test_name, exp_n, act_n));
    end
endtask

// lane 1 result in the same cycle as the previous one means they issued together
task automatic check_pairing(int idx);
    if (got_pair[idx] && (idx > 0)) begin
        if ((exp_addr[idx-1] == exp_addr[idx]) || (exp_rj[idx] == exp_addr[idx-1])
            || (exp_rk[idx] == exp_addr[idx-1])) begin
            stop_on_failure($sformatf("%s: writeback %0d issued together with a conflict",
                                      test_name, idx));
        end
    end
endtask

`endif

// ==== test/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

    localparam int IMEM_DEPTH      = 64;
    localparam int FB_DEPTH        = 4;
    localparam int AW              = $clog2(IMEM_DEPTH);
    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 6;
    // per word: one load cycle plus single-issue execution, with slack
    localparam int CYCLES_PER_INST = 4;
    localparam int TEST_CYCLES     = IMEM_DEPTH * CYCLES_PER_INST + RESET_CYCLES + 40;
    localparam int WATCHDOG_NS     = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

    logic          clk;
    logic          rstn;
    logic          load_we;
    logic [AW-1:0] load_addr;
    word_t         load_data;
    logic          wb_valid0;
    reg_addr_t     wb_addr0;
    word_t         wb_data0;
    logic          wb_valid1;
    reg_addr_t     wb_addr1;
    word_t         wb_data1;
    logic          idle;

    word_t         prog [IMEM_DEPTH];
    reg_addr_t     exp_addr [$];
    word_t         exp_data [$];
    reg_addr_t     exp_rj [$];
    reg_addr_t     exp_rk [$];
    reg_addr_t     got_addr [$];
    word_t         got_data [$];
    logic          got_pair [$];
    string         test_name;

    task automatic stop_on_failure(string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    `include "tb_model.svh"

    cpu_core #(.IMEM_DEPTH(IMEM_DEPTH), .FB_DEPTH(FB_DEPTH)) i_cpu_core (
        .clk(clk), .rstn(rstn), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data),
        .wb_valid0(wb_valid0), .wb_addr0(wb_addr0), .wb_data0(wb_data0),
        .wb_valid1(wb_valid1), .wb_addr1(wb_addr1), .wb_data1(wb_data1),
        .idle(idle)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // writeback stream, lane 0 first within a cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (wb_valid0) begin
                got_addr.push_back(wb_addr0);
                got_data.push_back(wb_data0);
                got_pair.push_back(1'b0);
            end
            if (wb_valid1) begin
                got_addr.push_back(wb_addr1);
                got_data.push_back(wb_data1);
                got_pair.push_back(wb_valid0);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_failure($sformatf("watchdog expired: run still going after %0d ns",
                                  WATCHDOG_NS));
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic clear_prog();
        foreach (prog[i]) begin
            prog[i] = '0;
        end
    endtask

    // load under reset, release, wait for idle, compare with model
    task automatic run_program(string name);
        int waited;
        test_name = name;
        next_cycle();
        rstn = 1'b0;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            load_we   = 1'b1;
            load_addr = AW'(i);
            load_data = prog[i];
            next_cycle();
        end
        load_we = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        got_addr.delete();
        got_data.delete();
        got_pair.delete();
        predict_writebacks();
        rstn   = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!idle) begin
            if (waited == IMEM_DEPTH * CYCLES_PER_INST) begin
                stop_on_failure($sformatf("%s: core never became idle", name));
            end
            waited++;
            @(negedge clk);
        end
        check_count(exp_addr.size(), got_addr.size());
        foreach (exp_addr[i]) begin
            check_wb(i, exp_addr[i], exp_data[i], got_addr[i], got_data[i]);
            check_pairing(i);
        end
    endtask

    task automatic test_all_nop();
        clear_prog();
        // a nop with a destination and an undefined opcode also stay silent
        prog[3]  = enc_r(OP_NOP, 5'd7, 5'd1, 5'd2);
        prog[10] = {6'h3f, 11'd0, 5'd2, 5'd1, 5'd6};
        run_program("all_nop");
    endtask

    task automatic test_alu_pairs();
        clear_prog();
        prog[0]  = enc_i(OP_ADDI, 5'd1, 5'd0, 100);
        prog[1]  = enc_i(OP_ADDI, 5'd2, 5'd0, -7);
        prog[2]  = enc_i(OP_ADDI, 5'd3, 5'd0, 2047);
        prog[3]  = enc_i(OP_ADDI, 5'd4, 5'd0, -2048);
        prog[4]  = enc_i(OP_ADDI, 5'd0, 5'd0, 5);
        prog[8]  = enc_r(OP_ADD, 5'd5, 5'd1, 5'd2);
        prog[9]  = enc_r(OP_SUB, 5'd6, 5'd2, 5'd3);
        prog[10] = enc_r(OP_AND, 5'd7, 5'd1, 5'd2);
        prog[11] = enc_r(OP_OR, 5'd8, 5'd3, 5'd4);
        prog[12] = enc_r(OP_XOR, 5'd9, 5'd2, 5'd4);
        prog[13] = enc_r(OP_SLT, 5'd10, 5'd2, 5'd1);
        prog[14] = enc_r(OP_SLT, 5'd11, 5'd1, 5'd2);
        prog[15] = enc_r(OP_SLT, 5'd12, 5'd4, 5'd3);
        prog[16] = enc_r(OP_ADD, 5'd0, 5'd1, 5'd1);
        prog[17] = enc_i(OP_ADDI, 5'd13, 5'd2, -1);
        run_program("alu_pairs");
    endtask

    task automatic test_multiply();
        clear_prog();
        prog[0]  = enc_i(OP_ADDI, 5'd1, 5'd0, -3);
        prog[1]  = enc_i(OP_ADDI, 5'd2, 5'd0, 1234);
        prog[2]  = enc_i(OP_ADDI, 5'd3, 5'd0, 2047);
        prog[3]  = enc_i(OP_ADDI, 5'd4, 5'd0, -2048);
        prog[8]  = enc_r(OP_MUL, 5'd5, 5'd1, 5'd2);
        prog[9]  = enc_r(OP_MUL, 5'd6, 5'd3, 5'd4);
        prog[10] = enc_r(OP_ADD, 5'd7, 5'd1, 5'd2);
        prog[11] = enc_r(OP_MUL, 5'd8, 5'd2, 5'd3);
        // square of r6 overflows 32 bits
        prog[16] = enc_r(OP_MUL, 5'd9, 5'd6, 5'd6);
        prog[17] = enc_r(OP_MUL, 5'd10, 5'd5, 5'd8);
        prog[18] = enc_i(OP_ADDI, 5'd11, 5'd0, 1);
        prog[19] = enc_r(OP_MUL, 5'd12, 5'd1, 5'd1);
        run_program("multiply");
    endtask

    task automatic test_pair_conflicts();
        clear_prog();
        prog[0]  = enc_i(OP_ADDI, 5'd1, 5'd0, 7);
        prog[1]  = enc_i(OP_ADDI, 5'd2, 5'd0, 9);
        // rewrites keep the old value, so the split pair still sees it
        prog[6]  = enc_r(OP_OR, 5'd1, 5'd1, 5'd0);
        prog[7]  = enc_r(OP_ADD, 5'd3, 5'd1, 5'd1);
        prog[8]  = enc_i(OP_ADDI, 5'd4, 5'd0, 1);
        prog[9]  = enc_i(OP_ADDI, 5'd4, 5'd0, 2);
        prog[10] = enc_r(OP_OR, 5'd2, 5'd2, 5'd0);
        prog[11] = enc_r(OP_SUB, 5'd6, 5'd0, 5'd2);
        prog[14] = enc_r(OP_ADD, 5'd7, 5'd4, 5'd0);
        run_program("pair_conflicts");
    endtask

    task automatic test_write_through();
        clear_prog();
        prog[0]  = enc_i(OP_ADDI, 5'd1, 5'd0, -77);
        prog[5]  = enc_i(OP_ADDI, 5'd2, 5'd1, 3);
        prog[6]  = enc_r(OP_ADD, 5'd3, 5'd1, 5'd1);
        prog[9]  = enc_i(OP_ADDI, 5'd4, 5'd0, 55);
        prog[14] = enc_r(OP_ADD, 5'd5, 5'd4, 5'd1);
        run_program("write_through");
    endtask

    // source whose last write lies at least five positions back
    function automatic reg_addr_t ready_source(input int last_wr [32], input int pos);
        reg_addr_t r;
        r = reg_addr_t'($urandom_range(0, 31));
        while (pos - last_wr[r] < 5) begin
            r = reg_addr_t'($urandom_range(0, 31));
        end
        return r;
    endfunction

    task automatic test_random_program();
        int        last_wr [32];
        int        pick;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        foreach (last_wr[r]) begin
            last_wr[r] = -8;
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            pick = $urandom_range(0, 11);
            rd   = reg_addr_t'($urandom_range(0, 31));
            rj   = ready_source(last_wr, i);
            rk   = ready_source(last_wr, i);
            case (pick)
                9, 10:   prog[i] = enc_i(OP_ADDI, rd, rj, $urandom_range(0, 4095));
                11:      prog[i] = {6'h2a, 26'($urandom)};
                default: prog[i] = enc_r(opcode_e'(pick), rd, rj, rk);
            endcase
            if ((pick >= 1) && (pick <= 10) && (rd != 0)) begin
                last_wr[rd] = i;
            end
        end
        run_program("random_program");
    endtask

    initial begin
        void'($urandom(32'h1281_8940));
        clk       = 1'b0;
        rstn      = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_all_nop();
        test_alu_pairs();
        test_multiply();
        test_pair_conflicts();
        test_write_through();
        test_random_program();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+test
source/cpu_pkg.sv
source/inst_mem.sv
source/fetch_buffer.sv
source/decoder.sv
source/dispatcher.sv
source/register_file.sv
source/exec_lane.sv
source/cpu_core.sv
test/tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - source/cpu_pkg.sv
  - source/inst_mem.sv
  - source/fetch_buffer.sv
  - source/decoder.sv
  - source/dispatcher.sv
  - source/register_file.sv
  - source/exec_lane.sv
  - source/cpu_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cpu_core.sv
